// ==== Bender.yml ====
package:
  name: led_frame_ctrl

sources:
  # Package first, then the blocks, then the top level
  - logic/led_frame_pkg.sv
  - logic/cmd_dispatch.sv
  - logic/frame_load.sv
  - logic/frame_buffer.sv
  - logic/led_frame_ctrl.sv

  # Testbench, top module tb_led_frame_ctrl
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/tb_led_frame_ctrl.sv

// ==== dv/tb_clock.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset; 100 ns clock, reset held for 5 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Released on a falling edge, like every other DUT input
    initial begin
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== dv/tb_led_frame_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the LED frame controller; drives commands on the byte
// stream, tracks them in a port-level model and reads the frame back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_led_frame_ctrl;
    import led_frame_pkg::*;

    localparam int WIDTH          = 4;
    localparam int HEIGHT         = 3;
    localparam int BPP            = 3;
    localparam int FRAME_BYTES    = WIDTH * HEIGHT * BPP;
    localparam int BYTES_SENT     = 2 * (FRAME_BYTES + 1) + 2 + 3;
    localparam int READS          = 3 * FRAME_BYTES;
    localparam int TIMEOUT_CYCLES = 4 * (BYTES_SENT + READS) + 200;
    localparam logic [7:0] OP_UNKNOWN = 8'hA5;

    typedef enum {EXP_OPCODE, EXP_FRAME, EXP_BRIGHT} expect_t;

    logic       clk;
    logic       reset;
    logic [7:0] in_data;
    logic       in_valid;
    logic       in_ready;
    fb_addr_t   rd_addr;
    logic [7:0] rd_data;
    logic [7:0] brightness;
    logic       frame_done;
    logic       cmd_error;

    logic [7:0]  model_mem [0:(1 << $bits(fb_addr_t)) - 1];
    logic [31:0] lfsr;
    logic        rd_req;          // Read issued on rd_addr this cycle
    logic        done_due;
    logic        err_due;
    logic        read_due;
    logic [7:0]  read_exp;
    logic [7:0]  bright_model;
    expect_t     mode;
    int          payload_k;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_start = 0;
    int          cycle_cnt = 0;
    int          done_pulses = 0;
    int          error_pulses = 0;
    int          ready_low_cycles = 0;
    int          bytes_accepted = 0;
    int          bytes_at_done = 0;   // Accepted bytes when frame_done was last seen

    tb_clock i_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    led_frame_ctrl #(
        .PIXEL_WIDTH     (WIDTH),
        .PIXEL_HEIGHT    (HEIGHT),
        .BYTES_PER_PIXEL (BPP)
    ) i_led_frame_ctrl (
        .clk        (clk),
        .reset      (reset),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .brightness (brightness),
        .frame_done (frame_done),
        .cmd_error  (cmd_error)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Payload byte k lands here; colour fastest, then column, then row, all downward
    function automatic fb_addr_t payload_addr(input int k);
        int       rev;
        fb_addr_t a;
        rev         = FRAME_BYTES - 1 - k;
        a.color_sel = MAX_COLOR_BITS'(rev % BPP);
        a.column    = MAX_COL_BITS'((rev / BPP) % WIDTH);
        a.row       = MAX_ROW_BITS'(rev / (BPP * WIDTH));
        return a;
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            val  = {val[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk);
        in_data  = b;
        in_valid = 1'b1;
        while (!in_ready) @(negedge clk);   // Taken on the next rising edge
    endtask

    task automatic idle_stream();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_frame(input bit gaps);
        logic [7:0] val;
        logic [7:0] gap;
        int         k;
        int         target;
        target = done_pulses + 1;
        send_byte(OP_READFRAME);
        for (k = 0; k < FRAME_BYTES; k++) begin
            if (gaps) begin
                draw_bits(2, gap);
                repeat (gap) idle_stream();
            end
            draw_bits(8, val);
            send_byte(val);
        end
        idle_stream();
        while (done_pulses < target) @(negedge clk);
    endtask

    task automatic read_frame();
        int k;
        for (k = 0; k < FRAME_BYTES; k++) begin
            @(negedge clk);
            rd_addr = payload_addr(k);
            rd_req  = 1'b1;
        end
        @(negedge clk);
        rd_req = 1'b0;
        @(negedge clk);   // Last compare is done by now
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", tests_run, name,
                     errors - test_err_start);
        end
        test_err_start = errors;
    endtask

    // Port-level model; values sampled here are the ones from before the edge
    always @(posedge clk) begin
        if (reset) begin
            done_due     = 1'b0;
            err_due      = 1'b0;
            read_due     = 1'b0;
            bright_model = 8'd0;
            mode         = EXP_OPCODE;
            payload_k    = 0;
        end else begin
            if (frame_done !== done_due) report_mismatch("frame_done", frame_done, done_due);
            if (in_ready !== !done_due) report_mismatch("in_ready", in_ready, !done_due);
            if (cmd_error !== err_due) report_mismatch("cmd_error", cmd_error, err_due);
            if (brightness !== bright_model) begin
                report_mismatch("brightness", brightness, bright_model);
            end
            if (read_due && rd_data !== read_exp) report_mismatch("rd_data", rd_data, read_exp);
            if (frame_done) begin
                done_pulses++;
                bytes_at_done = bytes_accepted;
            end
            if (cmd_error) error_pulses++;
            if (!in_ready) ready_low_cycles++;
            done_due = 1'b0;
            err_due  = 1'b0;
            read_due = rd_req;
            read_exp = model_mem[rd_addr];
            if (in_valid && in_ready) begin
                bytes_accepted++;
                case (mode)
                    EXP_OPCODE: begin
                        if (in_data == OP_READFRAME) begin
                            mode      = EXP_FRAME;
                            payload_k = 0;
                        end else if (in_data == OP_BRIGHTNESS) begin
                            mode = EXP_BRIGHT;
                        end else begin
                            err_due = 1'b1;
                        end
                    end
                    EXP_FRAME: begin
                        model_mem[payload_addr(payload_k)] = in_data;
                        payload_k++;
                        if (payload_k == FRAME_BYTES) begin
                            done_due = 1'b1;
                            mode     = EXP_OPCODE;
                        end
                    end
                    default: begin
                        bright_model = in_data;
                        mode         = EXP_OPCODE;
                    end
                endcase
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        logic [7:0] val;
        int         start;
        in_data  = 8'd0;
        in_valid = 1'b0;
        rd_addr  = '0;
        rd_req   = 1'b0;
        lfsr     = 32'h83a2;
        @(negedge reset);

        send_frame(1'b0);
        read_frame();
        finish_test("frame load and readback");

        if (done_pulses != 1) report_mismatch("frame_done pulse count", done_pulses, 1);
        if (ready_low_cycles != 1) report_mismatch("in_ready low cycles", ready_low_cycles, 1);
        if (bytes_at_done != FRAME_BYTES + 1) begin
            report_mismatch("accepted bytes at frame_done", bytes_at_done, FRAME_BYTES + 1);
        end
        finish_test("frame_done count");

        draw_bits(8, val);
        send_byte(OP_BRIGHTNESS);
        send_byte(val);
        idle_stream();
        if (brightness !== val) report_mismatch("brightness", brightness, val);
        read_frame();
        finish_test("brightness");

        start = error_pulses;
        draw_bits(8, val);
        if (val == brightness) val = ~val;   // Make the update visible
        send_byte(OP_UNKNOWN);
        send_byte(OP_BRIGHTNESS);
        send_byte(val);
        idle_stream();
        if (error_pulses != start + 1) report_mismatch("cmd_error pulse count", error_pulses,
                                                       start + 1);
        if (brightness !== val) report_mismatch("brightness", brightness, val);
        finish_test("unknown opcode");

        start = done_pulses;
        send_frame(1'b1);
        read_frame();
        if (done_pulses != start + 1) report_mismatch("frame_done pulse count", done_pulses,
                                                      start + 1);
        finish_test("gaps and overwrite");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
logic/led_frame_pkg.sv
logic/cmd_dispatch.sv
logic/frame_load.sv
logic/frame_buffer.sv
logic/led_frame_ctrl.sv
dv/tb_clock.sv
dv/tb_led_frame_ctrl.sv

// ==== logic/cmd_dispatch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command decoder; takes opcode bytes from the input stream and steers
// payload bytes to the frame loader or the brightness register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cmd_dispatch #(
    parameter int PIXEL_WIDTH     = 4,
    parameter int PIXEL_HEIGHT    = 3,
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic       clk,
    input  logic       reset,

    input  logic [7:0] in_data,
    input  logic       in_valid,
    output logic       in_ready,

    output logic [7:0] load_byte,
    output logic       load_en,
    input  logic       frame_done,

    output logic [7:0] brightness,
    output logic       cmd_error
);
    import led_frame_pkg::*;

    localparam int FRAME_BYTES = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int CNT_BITS    = $clog2(FRAME_BYTES + 1);

    typedef enum logic [1:0] {
        ST_OPCODE,
        ST_FRAME,
        ST_BRIGHT
    } dispatch_state_t;

    dispatch_state_t     state;
    logic                accept;
    logic [CNT_BITS-1:0] payload_cnt;   // Frame bytes handed to the loader

    // Only stall while the loader sits in its done cycle
    assign in_ready  = !(state == ST_FRAME && frame_done);
    assign accept    = in_valid && in_ready;

    assign load_en   = accept && (state == ST_FRAME);
    assign load_byte = in_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_OPCODE;
            brightness  <= 8'd0;
            cmd_error   <= 1'b0;
            payload_cnt <= '0;
        end else begin
            cmd_error <= 1'b0;
            case (state)
                ST_OPCODE: begin
                    if (accept) begin
                        case (in_data)
                            OP_READFRAME: begin
                                state       <= ST_FRAME;
                                payload_cnt <= '0;
                            end
                            OP_BRIGHTNESS: state <= ST_BRIGHT;
                            default: cmd_error <= 1'b1;   // Dropped; next byte is an opcode
                        endcase
                    end
                end
                ST_FRAME: begin
                    if (load_en) begin
                        payload_cnt <= payload_cnt + 1'b1;
                    end
                    if (frame_done) begin
                        state <= ST_OPCODE;
                    end
                end
                ST_BRIGHT: begin
                    if (accept) begin
                        brightness <= in_data;
                        state      <= ST_OPCODE;
                    end
                end
                default: state <= ST_OPCODE;
            endcase
        end
    end

    // Loader finishes exactly when the full frame has been forwarded
    a_done_after_full_frame: assert property (
        @(posedge clk) disable iff (reset)
        frame_done |-> (state == ST_FRAME) && (payload_cnt == CNT_BITS'(FRAME_BYTES))
    );

endmodule

// ==== logic/frame_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame RAM; one write port from the loader, one registered read port
// for the display scanner
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module frame_buffer #(
    parameter int PIXEL_WIDTH     = 4,
    parameter int PIXEL_HEIGHT    = 3,
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic                     clk,
    input  led_frame_pkg::fb_write_t fb_wr,
    input  led_frame_pkg::fb_addr_t  rd_addr,
    output logic [7:0]               rd_data
);
    import led_frame_pkg::*;

    localparam int DEPTH  = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int IDX_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [7:0]       mem [DEPTH];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // Row-major flattening, pixel bytes packed together
    function automatic logic [IDX_W-1:0] to_index(fb_addr_t a);
        return IDX_W'((a.row * PIXEL_WIDTH + a.column) * BYTES_PER_PIXEL + a.color_sel);
    endfunction

    assign wr_idx = to_index(fb_wr.addr);
    assign rd_idx = to_index(rd_addr);

    always_ff @(posedge clk) begin
        if (fb_wr.valid) begin
            mem[wr_idx] <= fb_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];   // One cycle read latency
    end

endmodule

// ==== logic/frame_load.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame loader; walks the buffer address downward, one write per byte,
// and pulses frame_done after the byte for row 0, column 0, colour 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module frame_load #(
    parameter int PIXEL_WIDTH     = 4,
    parameter int PIXEL_HEIGHT    = 3,
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [7:0]               load_byte,
    input  logic                     load_en,
    output led_frame_pkg::fb_write_t fb_wr,
    output logic                     frame_done
);
    import led_frame_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_DONE
    } load_state_t;

    // Top corner of the frame, where every load starts
    localparam fb_addr_t FIRST_ADDR = '{
        row:       MAX_ROW_BITS'(PIXEL_HEIGHT - 1),
        column:    MAX_COL_BITS'(PIXEL_WIDTH - 1),
        color_sel: MAX_COLOR_BITS'(BYTES_PER_PIXEL - 1)
    };

    load_state_t state;
    fb_addr_t    next_addr;
    fb_addr_t    wr_addr;
    logic        last_byte;

    // Colour byte moves fastest, then column, then row
    always_comb begin
        next_addr = fb_wr.addr;
        if (fb_wr.addr.color_sel != '0) begin
            next_addr.color_sel = fb_wr.addr.color_sel - 1'b1;
        end else begin
            next_addr.color_sel = FIRST_ADDR.color_sel;
            if (fb_wr.addr.column != '0) begin
                next_addr.column = fb_wr.addr.column - 1'b1;
            end else begin
                next_addr.column = FIRST_ADDR.column;
                next_addr.row    = fb_wr.addr.row - 1'b1;
            end
        end
    end

    assign wr_addr   = (state == ST_IDLE) ? FIRST_ADDR : next_addr;
    assign last_byte = (wr_addr == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            fb_wr      <= '0;
            frame_done <= 1'b0;
        end else begin
            case (state)
                ST_IDLE, ST_LOAD: begin
                    if (load_en) begin
                        fb_wr.valid <= 1'b1;
                        fb_wr.addr  <= wr_addr;
                        fb_wr.data  <= load_byte;
                        if (last_byte) begin
                            frame_done <= 1'b1;
                            state      <= ST_DONE;
                        end else begin
                            state <= ST_LOAD;
                        end
                    end else begin
                        fb_wr.valid <= 1'b0;   // Gap in the stream, keep position
                    end
                end
                ST_DONE: begin
                    fb_wr.valid <= 1'b0;
                    frame_done  <= 1'b0;
                    state       <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_addr_in_range: assert property (
        @(posedge clk) disable iff (reset)
        fb_wr.valid |-> (int'(fb_wr.addr.row) < PIXEL_HEIGHT)
            && (int'(fb_wr.addr.column) < PIXEL_WIDTH)
            && (int'(fb_wr.addr.color_sel) < BYTES_PER_PIXEL)
    );

    // Dispatcher holds the stream off while the loader closes a frame
    a_no_byte_in_done: assert property (
        @(posedge clk) disable iff (reset)
        (state == ST_DONE) |-> !load_en
    );

endmodule

// ==== logic/led_frame_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LED matrix controller command side; byte stream in, frame RAM and
// brightness out. Panel dimensions are set here and passed down
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module led_frame_ctrl #(
    parameter int PIXEL_WIDTH     = 4,
    parameter int PIXEL_HEIGHT    = 3,
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic [7:0]              in_data,
    input  logic                    in_valid,
    output logic                    in_ready,

    input  led_frame_pkg::fb_addr_t rd_addr,
    output logic [7:0]              rd_data,

    output logic [7:0]              brightness,
    output logic                    frame_done,
    output logic                    cmd_error
);
    import led_frame_pkg::*;

    logic [7:0] load_byte;
    logic       load_en;
    fb_write_t  fb_wr;

    cmd_dispatch #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HEIGHT    (PIXEL_HEIGHT),
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL)
    ) i_cmd_dispatch (
        .clk        (clk),
        .reset      (reset),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .load_byte  (load_byte),
        .load_en    (load_en),
        .frame_done (frame_done),
        .brightness (brightness),
        .cmd_error  (cmd_error)
    );

    frame_load #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HEIGHT    (PIXEL_HEIGHT),
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL)
    ) i_frame_load (
        .clk        (clk),
        .reset      (reset),
        .load_byte  (load_byte),
        .load_en    (load_en),
        .fb_wr      (fb_wr),
        .frame_done (frame_done)
    );

    frame_buffer #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HEIGHT    (PIXEL_HEIGHT),
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL)
    ) i_frame_buffer (
        .clk     (clk),
        .fb_wr   (fb_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// ==== logic/led_frame_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcodes, address widths and frame buffer structs for the LED frame
// controller; imported by every RTL block and by the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package led_frame_pkg;

    // Command opcodes, first byte of every command
    localparam logic [7:0] OP_READFRAME  = 8'h01;
    localparam logic [7:0] OP_BRIGHTNESS = 8'h02;

    // Widest panel the address fields can carry
    localparam int MAX_ROW_BITS   = 6;
    localparam int MAX_COL_BITS   = 6;
    localparam int MAX_COLOR_BITS = 2;

    // One byte location in the frame buffer
    typedef struct packed {
        logic [MAX_ROW_BITS-1:0]   row;
        logic [MAX_COL_BITS-1:0]   column;
        logic [MAX_COLOR_BITS-1:0] color_sel;   // Byte within the pixel
    } fb_addr_t;

    // Write request from the loader into the buffer
    typedef struct packed {
        logic       valid;
        fb_addr_t   addr;
        logic [7:0] data;
    } fb_write_t;

endpackage
